//--- source/me_pkg.sv
`default_nettype none

package me_pkg;

  // field widths of the memory-engine message header
  localparam int paddr_width_c    = 32;
  localparam int msg_type_width_c = 4;
  localparam int msg_size_width_c = 3;
  localparam int payload_width_c  = 8;

  // default data widths used by the top level
  // one lite message carries a full 32-byte block
  localparam int default_lite_width_c = 256;
  // burst beats are a quarter of that
  localparam int default_beat_width_c = 64;

  // physical address
  typedef logic [paddr_width_c-1:0] paddr_t;

  // message type code
  // also the bit index into the payload mask of the converter
  typedef logic [msg_type_width_c-1:0] msg_type_t;

  // log2 of message size in bytes
  // 0 is 1 byte, 7 is 128 bytes
  typedef logic [msg_size_width_c-1:0] msg_size_t;

  // opaque sideband bits, never looked at here
  typedef logic [payload_width_c-1:0] payload_t;

  // message header
  // travels untouched from the lite input to the burst header output
  typedef struct packed {
    msg_type_t msg_type;
    msg_size_t size;
    paddr_t    addr;
    payload_t  payload;
  } msg_header_s;

endpackage

`default_nettype wire

//--- source/me_lite_intake.sv
`default_nettype none

// four-phase req/ack capture for lite messages
// the message is held in a register and offered downstream as ready-and
module me_lite_intake
  #(parameter int lite_width_p = me_pkg::default_lite_width_c)
  (input  wire                     clk_i
  ,input  wire                     arst_n_i

  // four-phase side toward the outside
  ,input  wire                     req_i
  ,input  wire me_pkg::msg_header_s header_i
  ,input  wire [lite_width_p-1:0]  data_i
  ,output logic                    ack_o

  // ready-and side toward the converter
  ,output logic                    v_o
  ,output me_pkg::msg_header_s     header_o
  ,output logic [lite_width_p-1:0] data_o
  ,input  wire                     ready_i
  );

  logic full_r;
  logic ack_r;
  logic capture;
  logic release_msg;
  me_pkg::msg_header_s header_r;
  logic [lite_width_p-1:0] data_r;

  // new request, previous ack already dropped and a free register
  assign capture = req_i & ~ack_r & ~full_r;
  // downstream takes the held message
  assign release_msg = full_r & ready_i;

  // control flags
  // ack tracks the handshake only, so the outside can finish its cycle
  // while the converter is still busy with the held message
  always_ff @(posedge clk_i or negedge arst_n_i)
    begin
      if (!arst_n_i)
        begin
          full_r <= 1'b0;
          ack_r  <= 1'b0;
        end
      else
        begin
          // capture needs full_r low, so set and clear never collide
          if (capture)
            full_r <= 1'b1;
          else if (release_msg)
            full_r <= 1'b0;

          if (capture)
            ack_r <= 1'b1;
          // return to zero once req is seen low
          else if (ack_r & ~req_i)
            ack_r <= 1'b0;
        end
    end

  // message payload
  always_ff @(posedge clk_i)
    begin
      if (capture)
        begin
          header_r <= header_i;
          data_r   <= data_i;
        end
    end

  assign ack_o    = ack_r;
  assign v_o      = full_r;
  assign header_o = header_r;
  assign data_o   = data_r;

endmodule

`default_nettype wire

//--- source/me_lite_to_burst.sv
`default_nettype none

// splits one held lite message into a header beat and a data burst
// no storage for the message itself, the input must stay valid and stable
// until ready_o is seen, so the upstream link has to be ready-and
module me_lite_to_burst
  #(parameter int lite_width_p          = me_pkg::default_lite_width_c
   ,parameter int beat_width_p          = me_pkg::default_beat_width_c
   // set bit n marks message type n as carrying data
   ,parameter logic [15:0] payload_mask_p = 16'h0
   )
  (input  wire                     clk_i
  ,input  wire                     arst_n_i

  // lite input, ready-and
  ,input  wire                     v_i
  ,input  wire me_pkg::msg_header_s header_i
  ,input  wire [lite_width_p-1:0]  data_i
  ,output logic                    ready_o

  // burst header channel, ready-and
  ,output logic                    hdr_v_o
  ,output me_pkg::msg_header_s     hdr_o
  ,output logic                    hdr_has_data_o
  ,input  wire                     hdr_ready_i

  // burst data channel, ready-and
  ,output logic                    beat_v_o
  ,output logic [beat_width_p-1:0] beat_o
  ,output logic                    beat_last_o
  ,input  wire                     beat_ready_i
  );

  localparam int burst_words_lp = lite_width_p / beat_width_p;
  localparam int beat_bytes_lp  = beat_width_p / 8;
  localparam int cnt_width_lp   = (burst_words_lp > 1) ? $clog2(burst_words_lp) : 1;

  // parameter checks
  if (lite_width_p < beat_width_p)
    $fatal(1, "lite data narrower than a burst beat");
  if (lite_width_p % beat_width_p != 0)
    $fatal(1, "lite data width must be a multiple of the beat width");

  logic has_data;
  logic header_sent_r;
  logic hdr_fire;
  logic beat_fire;
  logic lite_fire;
  logic at_last;
  logic [31:0] msg_bytes;
  logic [31:0] num_beats;
  logic [cnt_width_lp-1:0] last_idx;
  logic [cnt_width_lp-1:0] beat_cnt_r;
  logic [burst_words_lp-1:0][beat_width_p-1:0] slices;

  // payload mask decides whether this type has a data burst at all
  assign has_data = payload_mask_p[header_i.msg_type];

  // burst length
  // at least one beat, never more than the lite word holds
  always_comb
    begin
      msg_bytes = 32'd1 << header_i.size;
      num_beats = msg_bytes / beat_bytes_lp;
      if (num_beats < 32'd1)
        num_beats = 32'd1;
      if (num_beats > burst_words_lp)
        num_beats = burst_words_lp;
      last_idx = cnt_width_lp'(num_beats - 32'd1);
    end

  // header side
  // header_sent_r drops hdr_v_o once the header is gone
  assign hdr_v_o        = v_i & ~header_sent_r;
  assign hdr_o          = header_i;
  assign hdr_has_data_o = has_data;
  assign hdr_fire       = hdr_v_o & hdr_ready_i;

  // data side
  // lowest slice goes first
  assign slices   = data_i;
  assign beat_o   = slices[beat_cnt_r];
  assign at_last  = (beat_cnt_r == last_idx);
  // early beats run alongside the header, but the last one waits for it
  // so the message is never released with the header still pending
  assign beat_v_o    = v_i & has_data & (~at_last | header_sent_r | hdr_fire);
  assign beat_last_o = beat_v_o & at_last;
  assign beat_fire   = beat_v_o & beat_ready_i;

  // data messages are done on the last beat, others on the header
  assign ready_o   = has_data ? (beat_fire & at_last) : hdr_fire;
  assign lite_fire = v_i & ready_o;

  always_ff @(posedge clk_i or negedge arst_n_i)
    begin
      if (!arst_n_i)
        begin
          header_sent_r <= 1'b0;
          beat_cnt_r    <= '0;
        end
      else
        begin
          // clear wins, header and message may go in the same cycle
          if (lite_fire)
            header_sent_r <= 1'b0;
          else if (hdr_fire)
            header_sent_r <= 1'b1;

          // beat index, wraps to zero at the end of the burst
          if (beat_fire)
            begin
              if (at_last)
                beat_cnt_r <= '0;
              else
                beat_cnt_r <= beat_cnt_r + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

//--- source/me_burst_out_buffer.sv
`default_nettype none

// two small queues toward the outside, one per burst channel
// headers can run ahead of the beats of an earlier message
module me_burst_out_buffer
  #(parameter int beat_width_p = me_pkg::default_beat_width_c)
  (input  wire                     clk_i
  ,input  wire                     arst_n_i

  // from the converter
  ,input  wire                     hdr_v_i
  ,input  wire me_pkg::msg_header_s hdr_i
  ,input  wire                     hdr_has_data_i
  ,output logic                    hdr_ready_o
  ,input  wire                     beat_v_i
  ,input  wire [beat_width_p-1:0]  beat_i
  ,input  wire                     beat_last_i
  ,output logic                    beat_ready_o

  // to the outside
  ,output logic                    hdr_v_o
  ,output me_pkg::msg_header_s     hdr_o
  ,output logic                    hdr_has_data_o
  ,input  wire                     hdr_ready_i
  ,output logic                    beat_v_o
  ,output logic [beat_width_p-1:0] beat_o
  ,output logic                    beat_last_o
  ,input  wire                     beat_ready_i
  );

  // channel index of each queue in the control vectors
  localparam int hdr_ch_lp  = 0;
  localparam int beat_ch_lp = 1;

  typedef struct packed {
    me_pkg::msg_header_s hdr;
    logic                has_data;
  } hdr_entry_s;

  typedef struct packed {
    logic [beat_width_p-1:0] data;
    logic                    last;
  } beat_entry_s;

  // pointers carry one wrap bit above the 1-bit slot index
  logic [1:0][1:0] wptr_r;
  logic [1:0][1:0] rptr_r;
  logic [1:0] push;
  logic [1:0] pop;
  logic [1:0] full;
  logic [1:0] empty;
  hdr_entry_s  hdr_mem_r  [2];
  beat_entry_s beat_mem_r [2];
  hdr_entry_s  hdr_head;
  beat_entry_s beat_head;

  // same control for both queues
  for (genvar i = 0; i < 2; i++)
    begin : g_ctl
      assign empty[i] = (wptr_r[i] == rptr_r[i]);
      // same slot, different lap
      assign full[i]  = (wptr_r[i][0] == rptr_r[i][0]) & (wptr_r[i][1] != rptr_r[i][1]);
    end

  assign push[hdr_ch_lp]  = hdr_v_i & ~full[hdr_ch_lp];
  assign push[beat_ch_lp] = beat_v_i & ~full[beat_ch_lp];
  assign pop[hdr_ch_lp]   = ~empty[hdr_ch_lp] & hdr_ready_i;
  assign pop[beat_ch_lp]  = ~empty[beat_ch_lp] & beat_ready_i;

  always_ff @(posedge clk_i or negedge arst_n_i)
    begin
      if (!arst_n_i)
        begin
          wptr_r <= '0;
          rptr_r <= '0;
        end
      else
        begin
          for (int i = 0; i < 2; i++)
            begin
              if (push[i])
                wptr_r[i] <= wptr_r[i] + 2'd1;
              if (pop[i])
                rptr_r[i] <= rptr_r[i] + 2'd1;
            end
        end
    end

  // queue storage
  always_ff @(posedge clk_i)
    begin
      if (push[hdr_ch_lp])
        hdr_mem_r[wptr_r[hdr_ch_lp][0]] <= '{hdr: hdr_i, has_data: hdr_has_data_i};
      if (push[beat_ch_lp])
        beat_mem_r[wptr_r[beat_ch_lp][0]] <= '{data: beat_i, last: beat_last_i};
    end

  assign hdr_head  = hdr_mem_r[rptr_r[hdr_ch_lp][0]];
  assign beat_head = beat_mem_r[rptr_r[beat_ch_lp][0]];

  // a full queue stalls the converter
  assign hdr_ready_o  = ~full[hdr_ch_lp];
  assign beat_ready_o = ~full[beat_ch_lp];

  assign hdr_v_o        = ~empty[hdr_ch_lp];
  assign hdr_o          = hdr_head.hdr;
  assign hdr_has_data_o = hdr_head.has_data;
  assign beat_v_o       = ~empty[beat_ch_lp];
  assign beat_o         = beat_head.data;
  // last only qualified by a valid beat
  assign beat_last_o    = ~empty[beat_ch_lp] & beat_head.last;

endmodule

`default_nettype wire

//--- source/me_lite_burst_top.sv
`default_nettype none

// lite in, burst out
// intake -> converter -> output buffer
module me_lite_burst_top
  #(parameter int lite_width_p            = me_pkg::default_lite_width_c
   ,parameter int beat_width_p            = me_pkg::default_beat_width_c
   ,parameter logic [15:0] payload_mask_p = 16'h0
   )
  (input  wire                     clk_i
  ,input  wire                     arst_n_i

  // four-phase lite input
  ,input  wire                     req_i
  ,input  wire me_pkg::msg_header_s header_i
  ,input  wire [lite_width_p-1:0]  data_i
  ,output logic                    ack_o

  // burst header output
  ,output logic                    hdr_v_o
  ,output me_pkg::msg_header_s     hdr_o
  ,output logic                    hdr_has_data_o
  ,input  wire                     hdr_ready_i

  // burst data output
  ,output logic                    beat_v_o
  ,output logic [beat_width_p-1:0] beat_o
  ,output logic                    beat_last_o
  ,input  wire                     beat_ready_i
  );

  // intake to converter
  logic                    lite_v;
  me_pkg::msg_header_s     lite_header;
  logic [lite_width_p-1:0] lite_data;
  logic                    lite_ready;

  // converter to buffer
  logic                    hdr_v;
  me_pkg::msg_header_s     hdr;
  logic                    hdr_has_data;
  logic                    hdr_ready;
  logic                    beat_v;
  logic [beat_width_p-1:0] beat;
  logic                    beat_last;
  logic                    beat_ready;

  me_lite_intake
    #(.lite_width_p(lite_width_p))
    intake0
    (.clk_i    (clk_i)
    ,.arst_n_i (arst_n_i)
    ,.req_i    (req_i)
    ,.header_i (header_i)
    ,.data_i   (data_i)
    ,.ack_o    (ack_o)
    ,.v_o      (lite_v)
    ,.header_o (lite_header)
    ,.data_o   (lite_data)
    ,.ready_i  (lite_ready)
    );

  me_lite_to_burst
    #(.lite_width_p   (lite_width_p)
     ,.beat_width_p   (beat_width_p)
     ,.payload_mask_p (payload_mask_p))
    conv0
    (.clk_i          (clk_i)
    ,.arst_n_i       (arst_n_i)
    ,.v_i            (lite_v)
    ,.header_i       (lite_header)
    ,.data_i         (lite_data)
    ,.ready_o        (lite_ready)
    ,.hdr_v_o        (hdr_v)
    ,.hdr_o          (hdr)
    ,.hdr_has_data_o (hdr_has_data)
    ,.hdr_ready_i    (hdr_ready)
    ,.beat_v_o       (beat_v)
    ,.beat_o         (beat)
    ,.beat_last_o    (beat_last)
    ,.beat_ready_i   (beat_ready)
    );

  me_burst_out_buffer
    #(.beat_width_p(beat_width_p))
    obuf0
    (.clk_i          (clk_i)
    ,.arst_n_i       (arst_n_i)
    ,.hdr_v_i        (hdr_v)
    ,.hdr_i          (hdr)
    ,.hdr_has_data_i (hdr_has_data)
    ,.hdr_ready_o    (hdr_ready)
    ,.beat_v_i       (beat_v)
    ,.beat_i         (beat)
    ,.beat_last_i    (beat_last)
    ,.beat_ready_o   (beat_ready)
    ,.hdr_v_o        (hdr_v_o)
    ,.hdr_o          (hdr_o)
    ,.hdr_has_data_o (hdr_has_data_o)
    ,.hdr_ready_i    (hdr_ready_i)
    ,.beat_v_o       (beat_v_o)
    ,.beat_o         (beat_o)
    ,.beat_last_o    (beat_last_o)
    ,.beat_ready_i   (beat_ready_i)
    );

endmodule

`default_nettype wire

//--- test/me_lite_burst_asserts.sv
`default_nettype none

// protocol checks on the four-phase input and the two burst outputs
module me_lite_burst_asserts
  #(parameter int beat_width_p = me_pkg::default_beat_width_c)
  (input wire                      clk_i
  ,input wire                      arst_n_i
  ,input wire                      req_i
  ,input wire                      ack_i
  ,input wire                      hdr_v_i
  ,input wire me_pkg::msg_header_s hdr_i
  ,input wire                      hdr_has_data_i
  ,input wire                      hdr_ready_i
  ,input wire                      beat_v_i
  ,input wire [beat_width_p-1:0]   beat_i
  ,input wire                      beat_last_i
  ,input wire                      beat_ready_i
  );

  // a stalled header stays valid and unchanged
  hdr_hold_a : assert property (@(posedge clk_i) disable iff (!arst_n_i)
    hdr_v_i && !hdr_ready_i |=> hdr_v_i && $stable(hdr_i) && $stable(hdr_has_data_i))
    else $error("header output changed while stalled");

  // same for a stalled beat
  beat_hold_a : assert property (@(posedge clk_i) disable iff (!arst_n_i)
    beat_v_i && !beat_ready_i |=> beat_v_i && $stable(beat_i) && $stable(beat_last_i))
    else $error("beat output changed while stalled");

  // ack only rises in answer to a request
  ack_rise_a : assert property (@(posedge clk_i) disable iff (!arst_n_i)
    !req_i && !ack_i |=> !ack_i)
    else $error("ack rose without a request");

  // last without a beat makes no sense
  last_with_beat_a : assert property (@(posedge clk_i) disable iff (!arst_n_i)
    beat_last_i |-> beat_v_i)
    else $error("beat_last_o high without beat_v_o");

endmodule

bind me_lite_burst_top me_lite_burst_asserts
  #(.beat_width_p(beat_width_p))
  asserts0
  (.clk_i          (clk_i)
  ,.arst_n_i       (arst_n_i)
  ,.req_i          (req_i)
  ,.ack_i          (ack_o)
  ,.hdr_v_i        (hdr_v_o)
  ,.hdr_i          (hdr_o)
  ,.hdr_has_data_i (hdr_has_data_o)
  ,.hdr_ready_i    (hdr_ready_i)
  ,.beat_v_i       (beat_v_o)
  ,.beat_i         (beat_o)
  ,.beat_last_i    (beat_last_o)
  ,.beat_ready_i   (beat_ready_i)
  );

`default_nettype wire

//--- test/tb_me_lite_burst.sv
`default_nettype none

// testbench for the lite to burst subsystem
// random four-phase messages in, both burst channels checked against a model
module tb_me_lite_burst;

  localparam int lite_width_c  = 256;
  localparam int beat_width_c  = 64;
  localparam int beat_bytes_c  = beat_width_c / 8;
  // types 1, 3 and 9 carry data
  localparam logic [15:0] payload_mask_c = 16'h020a;
  localparam int num_msgs_c    = 200;
  localparam int clk_period_c  = 20;
  // 40 cycles per message plus reset and drain margin
  localparam int watchdog_time_c = (num_msgs_c * 40 + 20) * clk_period_c;

  // expected header entry
  typedef struct packed {
    me_pkg::msg_header_s hdr;
    logic                has_data;
  } exp_hdr_s;

  // expected beat entry
  typedef struct packed {
    logic [beat_width_c-1:0] data;
    logic                    last;
  } exp_beat_s;

  logic clk_i = 1'b0;
  logic arst_n_i;
  logic req_i;
  me_pkg::msg_header_s header_i;
  logic [lite_width_c-1:0] data_i;
  logic ack_o;
  logic hdr_v_o;
  me_pkg::msg_header_s hdr_o;
  logic hdr_has_data_o;
  logic hdr_ready_i;
  logic beat_v_o;
  logic [beat_width_c-1:0] beat_o;
  logic beat_last_o;
  logic beat_ready_i;

  integer seed = 32'h504f9c0a;
  exp_hdr_s  exp_hdr_q[$];
  exp_beat_s exp_beat_q[$];
  exp_hdr_s  hdr_want;
  exp_beat_s beat_want;
  int hdr_matched = 0;
  int beat_matched = 0;
  // total beats the model asked for over the whole run
  int beat_expected = 0;
  me_pkg::msg_header_s hdr_tmp;
  logic [lite_width_c-1:0] data_tmp;

  me_lite_burst_top
    #(.lite_width_p   (lite_width_c)
     ,.beat_width_p   (beat_width_c)
     ,.payload_mask_p (payload_mask_c))
    dut0
    (.clk_i          (clk_i)
    ,.arst_n_i       (arst_n_i)
    ,.req_i          (req_i)
    ,.header_i       (header_i)
    ,.data_i         (data_i)
    ,.ack_o          (ack_o)
    ,.hdr_v_o        (hdr_v_o)
    ,.hdr_o          (hdr_o)
    ,.hdr_has_data_o (hdr_has_data_o)
    ,.hdr_ready_i    (hdr_ready_i)
    ,.beat_v_o       (beat_v_o)
    ,.beat_o         (beat_o)
    ,.beat_last_o    (beat_last_o)
    ,.beat_ready_i   (beat_ready_i)
    );

  always #(clk_period_c / 2) clk_i = ~clk_i;

  // reference model
  // data types send max(1, bytes / beat bytes) beats, others none
  function automatic int ref_beat_count(me_pkg::msg_header_s h);
    int bytes;
    int beats;
    bytes = 1 << h.size;
    beats = bytes / beat_bytes_c;
    if (!payload_mask_c[h.msg_type])
      return 0;
    if (beats < 1)
      beats = 1;
    return beats;
  endfunction

  // beat idx of a lite word, lowest slice first
  function automatic logic [beat_width_c-1:0] ref_beat(logic [lite_width_c-1:0] d, int idx);
    return d[idx*beat_width_c +: beat_width_c];
  endfunction

  task automatic fail_now(input string msg);
    $display("ERROR at time %0t: %s", $time, msg);
    $display("TEST FAILED");
    $fatal(1, "run stopped on error");
  endtask

  task automatic check_value(input string what, input logic [63:0] got, input logic [63:0] want);
    if (got !== want)
      begin
        $display("MISMATCH at time %0t: %s got %h expected %h", $time, what, got, want);
        $display("TEST FAILED");
        $fatal(1, "run stopped on mismatch");
      end
  endtask

  // nothing may come out before the first request
  task automatic check_idle();
    check_value("ack_o while idle", 64'(ack_o), 64'd0);
    check_value("hdr_v_o while idle", 64'(hdr_v_o), 64'd0);
    check_value("beat_v_o while idle", 64'(beat_v_o), 64'd0);
  endtask

  // queue the expected header and beats of one message
  task automatic expect_message(input me_pkg::msg_header_s h, input logic [lite_width_c-1:0] d);
    int n;
    exp_hdr_s eh;
    exp_beat_s eb;
    n = ref_beat_count(h);
    eh.hdr = h;
    eh.has_data = (n > 0);
    exp_hdr_q.push_back(eh);
    beat_expected += n;
    for (int i = 0; i < n; i++)
      begin
        eb.data = ref_beat(d, i);
        eb.last = (i == n - 1);
        exp_beat_q.push_back(eb);
      end
  endtask

  // random message, the first three are fixed corner cases
  // size stays within 32 bytes, the width of one lite word
  task automatic make_message(input int idx, output me_pkg::msg_header_s h,
                              output logic [lite_width_c-1:0] d);
    for (int w = 0; w < lite_width_c / 32; w++)
      d[w*32 +: 32] = $random(seed);
    h.msg_type = me_pkg::msg_type_t'($random(seed));
    h.size     = me_pkg::msg_size_t'($unsigned($random(seed)) % 6);
    h.addr     = $random(seed);
    h.payload  = me_pkg::payload_t'($random(seed));
    case (idx)
      // type without data
      0:
        begin
          h.msg_type = 4'd0;
          h.size     = 3'd5;
        end
      // 8 bytes, single beat
      1:
        begin
          h.msg_type = 4'd1;
          h.size     = 3'd3;
        end
      // 32 bytes, four beats
      2:
        begin
          h.msg_type = 4'd3;
          h.size     = 3'd5;
        end
      default:
        begin
        end
    endcase
  endtask

  // random back-pressure, ready about three cycles in four
  initial
    begin
      hdr_ready_i  = 1'b0;
      beat_ready_i = 1'b0;
      forever
        begin
          @(negedge clk_i);
          hdr_ready_i  = ($random(seed) % 4) != 0;
          beat_ready_i = ($random(seed) % 4) != 0;
        end
    end

  // compare every accepted output with the head of its queue
  always @(posedge clk_i)
    begin
      if (arst_n_i && hdr_v_o && hdr_ready_i)
        begin
          if (exp_hdr_q.size() == 0)
            fail_now("a header came out with no message pending");
          else
            begin
              hdr_want = exp_hdr_q.pop_front();
              check_value("header", 64'(hdr_o), 64'(hdr_want.hdr));
              check_value("hdr_has_data_o", 64'(hdr_has_data_o), 64'(hdr_want.has_data));
              hdr_matched++;
            end
        end
      if (arst_n_i && beat_v_o && beat_ready_i)
        begin
          if (exp_beat_q.size() == 0)
            fail_now("a data beat came out with no beat pending");
          else
            begin
              beat_want = exp_beat_q.pop_front();
              check_value("beat data", 64'(beat_o), 64'(beat_want.data));
              check_value("beat_last_o", 64'(beat_last_o), 64'(beat_want.last));
              beat_matched++;
            end
        end
    end

  // four-phase driver and end of run
  initial
    begin
      arst_n_i = 1'b0;
      req_i    = 1'b0;
      header_i = '0;
      data_i   = '0;
      repeat (2)
        begin
          @(negedge clk_i);
          check_idle();
        end
      arst_n_i = 1'b1;
      repeat (3)
        begin
          @(negedge clk_i);
          check_idle();
        end
      for (int n = 0; n < num_msgs_c; n++)
        begin
          make_message(n, hdr_tmp, data_tmp);
          expect_message(hdr_tmp, data_tmp);
          header_i = hdr_tmp;
          data_i   = data_tmp;
          req_i    = 1'b1;
          @(negedge clk_i);
          while (!ack_o)
            @(negedge clk_i);
          req_i = 1'b0;
          while (ack_o)
            @(negedge clk_i);
        end
      while (exp_hdr_q.size() != 0 || exp_beat_q.size() != 0)
        @(negedge clk_i);
      // a few idle cycles so any extra output hits an empty queue
      repeat (10)
        @(negedge clk_i);
      if (hdr_matched == num_msgs_c && beat_matched == beat_expected &&
          exp_hdr_q.size() == 0 && exp_beat_q.size() == 0)
        begin
          $display("TEST OK");
          $finish;
        end
      else
        begin
          fail_now("header or beat count or expected queues wrong at end of run");
        end
    end

  // watchdog
  initial
    begin
      #(watchdog_time_c);
      fail_now("timeout, the messages did not all complete");
    end

endmodule

`default_nettype wire

//--- flist.f
source/me_pkg.sv
source/me_lite_intake.sv
source/me_lite_to_burst.sv
source/me_burst_out_buffer.sv
source/me_lite_burst_top.sv
test/me_lite_burst_asserts.sv
test/tb_me_lite_burst.sv
